// ==== design/controlSignalTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSignalTable import controlUnitPkg::*; (
	input logic [stateWidth-1:0] state,
	input logic [operationWidth-1:0] currentOp,
	output logic iorD,
	output logic irWrite,
	output logic [1:0] pcSource,
	output logic pcWrite,
	output logic memRead,
	output logic memWrite,
	output logic exceptionVector,
	output logic [1:0] memToReg,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [2:0] aluOp,
	output logic [1:0] shiftOp,
	output logic [1:0] shiftAmountSrc,
	output logic shiftValueSrc,
	output logic [1:0] intCause,
	output logic causeWrite,
	output logic epcWrite,
	output logic [1:0] regDst,
	output logic regWrite
);

	always_comb begin
		// every select idles at its zero encoding
		iorD = 1'b0;
		irWrite = 1'b0;
		pcSource = pcAluResult;
		pcWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		exceptionVector = vecIllegal;
		memToReg = wbAluOut;
		aluSrcA = srcAPc;
		aluSrcB = srcBRegB;
		aluOp = aluLoad;
		shiftOp = shNone;
		shiftAmountSrc = amtRs;
		shiftValueSrc = valRt;
		intCause = causeIllegal;
		causeWrite = 1'b0;
		epcWrite = 1'b0;
		regDst = dstRt;
		regWrite = 1'b0;
		case (state)
			stFetch: begin
				memRead = 1'b1;
				aluSrcB = srcBFour;
				aluOp = aluAdd;
			end
			stFetchWrite: begin
				irWrite = 1'b1;
				pcWrite = 1'b1;
				aluSrcB = srcBFour;
				aluOp = aluAdd;
			end
			stDecode: begin
				// branch target precomputed while decoding
				aluSrcB = srcBImmShifted;
				aluOp = aluAdd;
			end
			stAluExecute: begin
				aluSrcA = srcARegA;
				case (currentOp)
					opAddOp: aluOp = aluAdd;
					opSubOp: aluOp = aluSub;
					opAndOp: aluOp = aluAnd;
					opSltOp: aluOp = aluSlt;
					default: aluOp = aluLoad;
				endcase
			end
			stImmExecute, stAddressCompute: begin
				aluSrcA = srcARegA;
				aluSrcB = srcBImm;
				aluOp = aluAdd;
			end
			stAluWriteBack: begin
				regDst = dstRd;
				regWrite = 1'b1;
			end
			stImmWriteBack, stLoadWriteBack: begin
				memToReg = (state == stLoadWriteBack) ? wbMemData : wbAluOut;
				regWrite = 1'b1;
			end
			stShiftExecute: begin
				case (currentOp)
					opSrlOp: shiftOp = shSrl;
					opSraOp, opSravOp: shiftOp = shSra;
					default: shiftOp = shSll;
				endcase
				if (currentOp == opLuiOp) begin
					// lui shifts the immediate left by sixteen
					shiftAmountSrc = amtSixteen;
					shiftValueSrc = valImmediate;
				end else if (currentOp == opSllvOp || currentOp == opSravOp) begin
					shiftAmountSrc = amtRs;
				end else begin
					shiftAmountSrc = amtShamt;
				end
			end
			stShiftWriteBack: begin
				memToReg = wbShiftResult;
				regDst = (currentOp == opLuiOp) ? dstRt : dstRd;
				regWrite = 1'b1;
			end
			stLoadWait: begin
				iorD = 1'b1;
				memRead = 1'b1;
			end
			stStoreWrite: begin
				iorD = 1'b1;
				memWrite = 1'b1;
			end
			stJumpLink: begin
				regDst = dstRa;
				memToReg = wbPcLink;
				regWrite = 1'b1;
			end
			stJump: begin
				pcSource = pcJumpTarget;
				pcWrite = 1'b1;
			end
			stJumpRegister: begin
				// rs passes through the ALU to the PC
				aluSrcA = srcARegA;
				pcWrite = 1'b1;
			end
			stReturn: begin
				pcSource = pcEpc;
				pcWrite = 1'b1;
			end
			stOverflowTrap, stIllegalTrap: begin
				// epc gets pc minus four, then jump to the handler
				aluSrcB = srcBFour;
				aluOp = aluSub;
				epcWrite = 1'b1;
				causeWrite = 1'b1;
				pcSource = pcExceptionVector;
				pcWrite = 1'b1;
				if (state == stOverflowTrap) begin
					intCause = causeOverflow;
					exceptionVector = vecOverflow;
				end
			end
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import controlUnitPkg::*; (
	input logic clk,
	input logic reset,
	input logic [instrWidth-1:0] instruction,
	input logic overflow,
	output logic iorD,
	output logic irWrite,
	output logic [1:0] pcSource,
	output logic pcWrite,
	output logic memRead,
	output logic memWrite,
	output logic exceptionVector,
	output logic [1:0] memToReg,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [2:0] aluOp,
	output logic [1:0] shiftOp,
	output logic [1:0] shiftAmountSrc,
	output logic shiftValueSrc,
	output logic [1:0] intCause,
	output logic causeWrite,
	output logic epcWrite,
	output logic [1:0] regDst,
	output logic regWrite
);

	logic [operationWidth-1:0] decodedOp;
	logic [operationWidth-1:0] currentOp;
	logic [stateWidth-1:0] state;

	instructionDecoder decoder (
		.instruction(instruction),
		.decodedOp(decodedOp)
	);

	stateSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.decodedOp(decodedOp),
		.overflow(overflow),
		.state(state),
		.currentOp(currentOp)
	);

	// outputs come only from registered state and operation
	controlSignalTable signalTable (
		.state(state),
		.currentOp(currentOp),
		.iorD(iorD),
		.irWrite(irWrite),
		.pcSource(pcSource),
		.pcWrite(pcWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.exceptionVector(exceptionVector),
		.memToReg(memToReg),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.shiftAmountSrc(shiftAmountSrc),
		.shiftValueSrc(shiftValueSrc),
		.intCause(intCause),
		.causeWrite(causeWrite),
		.epcWrite(epcWrite),
		.regDst(regDst),
		.regWrite(regWrite)
	);

endmodule

`default_nettype wire

// ==== design/controlUnitPkg.sv ====
`default_nettype none

package controlUnitPkg;

	localparam int instrWidth = 32;
	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;
	localparam int operationWidth = 5;
	localparam int stateWidth = 5;

	// memory answers within this many cycles
	localparam int memWaitCycles = 3;
	localparam int waitCountWidth = $clog2(memWaitCycles);

	localparam logic [opcodeWidth-1:0]
		opRType = 6'd0,
		opJ = 6'd2,
		opJal = 6'd3,
		opAddi = 6'd8,
		opAddiu = 6'd9,
		opLui = 6'd15,
		opLw = 6'd35,
		opSw = 6'd43;

	localparam logic [functWidth-1:0]
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnSra = 6'd3,
		fnSllv = 6'd4,
		fnSrav = 6'd7,
		fnJr = 6'd8,
		fnRte = 6'd19,
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnSlt = 6'd42;

	// one code per supported instruction
	localparam logic [operationWidth-1:0]
		opAddOp = 5'd0,
		opSubOp = 5'd1,
		opAndOp = 5'd2,
		opSltOp = 5'd3,
		opSllOp = 5'd4,
		opSrlOp = 5'd5,
		opSraOp = 5'd6,
		opSllvOp = 5'd7,
		opSravOp = 5'd8,
		opJrOp = 5'd9,
		opRteOp = 5'd10,
		opAddiOp = 5'd11,
		opAddiuOp = 5'd12,
		opLuiOp = 5'd13,
		opLwOp = 5'd14,
		opSwOp = 5'd15,
		opJOp = 5'd16,
		opJalOp = 5'd17,
		opIllegal = 5'd18;

	localparam logic [stateWidth-1:0]
		stFetch = 5'd0,
		stFetchWrite = 5'd1,
		stDecode = 5'd2,
		stAluExecute = 5'd3,
		stAluWriteBack = 5'd4,
		stImmExecute = 5'd5,
		stImmWriteBack = 5'd6,
		stShiftExecute = 5'd7,
		stShiftWriteBack = 5'd8,
		stAddressCompute = 5'd9,
		stLoadWait = 5'd10,
		stLoadWriteBack = 5'd11,
		stStoreWrite = 5'd12,
		stJumpLink = 5'd13,
		stJump = 5'd14,
		stJumpRegister = 5'd15,
		stReturn = 5'd16,
		stOverflowTrap = 5'd17,
		stIllegalTrap = 5'd18;

	// datapath select encodings
	localparam logic [1:0] pcAluResult = 2'd0;
	localparam logic [1:0] pcExceptionVector = 2'd1;
	localparam logic [1:0] pcJumpTarget = 2'd2;
	localparam logic [1:0] pcEpc = 2'd3;
	localparam logic srcAPc = 1'b0;
	localparam logic srcARegA = 1'b1;
	localparam logic [1:0] srcBRegB = 2'd0;
	localparam logic [1:0] srcBFour = 2'd1;
	localparam logic [1:0] srcBImm = 2'd2;
	localparam logic [1:0] srcBImmShifted = 2'd3;
	localparam logic [2:0] aluLoad = 3'd0;
	localparam logic [2:0] aluAdd = 3'd1;
	localparam logic [2:0] aluSub = 3'd2;
	localparam logic [2:0] aluAnd = 3'd3;
	localparam logic [2:0] aluSlt = 3'd7;
	localparam logic [1:0] shNone = 2'd0;
	localparam logic [1:0] shSll = 2'd1;
	localparam logic [1:0] shSrl = 2'd2;
	localparam logic [1:0] shSra = 2'd3;
	localparam logic [1:0] amtRs = 2'd0;
	localparam logic [1:0] amtShamt = 2'd1;
	localparam logic [1:0] amtSixteen = 2'd2;
	localparam logic valRt = 1'b0;
	localparam logic valImmediate = 1'b1;
	localparam logic [1:0] wbAluOut = 2'd0;
	localparam logic [1:0] wbMemData = 2'd1;
	localparam logic [1:0] wbShiftResult = 2'd2;
	localparam logic [1:0] wbPcLink = 2'd3;
	localparam logic [1:0] dstRt = 2'd0;
	localparam logic [1:0] dstRd = 2'd1;
	localparam logic [1:0] dstRa = 2'd2;
	localparam logic [1:0] causeIllegal = 2'd0;
	localparam logic [1:0] causeOverflow = 2'd1;
	localparam logic vecIllegal = 1'b0;
	localparam logic vecOverflow = 1'b1;

	// the instruction register seen as R-format or I-format
	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [functWidth-1:0] funct;
		} rFormat;
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] immediate;
		} iFormat;
	} instrWord;

endpackage

`default_nettype wire

// ==== design/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder import controlUnitPkg::*; (
	input instrWord instruction,
	output logic [operationWidth-1:0] decodedOp
);

	// sll, srl and sra are the only functions that carry a shift amount
	logic immediateShift;

	assign immediateShift = (instruction.rFormat.funct == fnSll) ||
		(instruction.rFormat.funct == fnSrl) ||
		(instruction.rFormat.funct == fnSra);

	always_comb begin
		decodedOp = opIllegal;
		case (instruction.iFormat.opcode)
			opRType: begin
				case (instruction.rFormat.funct)
					fnAdd: decodedOp = opAddOp;
					fnSub: decodedOp = opSubOp;
					fnAnd: decodedOp = opAndOp;
					fnSlt: decodedOp = opSltOp;
					fnSll: decodedOp = opSllOp;
					fnSrl: decodedOp = opSrlOp;
					fnSra: decodedOp = opSraOp;
					fnSllv: decodedOp = opSllvOp;
					fnSrav: decodedOp = opSravOp;
					fnJr: decodedOp = opJrOp;
					fnRte: decodedOp = opRteOp;
					default: decodedOp = opIllegal;
				endcase
				// stray shamt bits make the word illegal
				if (!immediateShift && instruction.rFormat.shamt != 5'd0) begin
					decodedOp = opIllegal;
				end
			end
			opJ: begin
				decodedOp = opJOp;
			end
			opJal: begin
				decodedOp = opJalOp;
			end
			opAddi: begin
				decodedOp = opAddiOp;
			end
			opAddiu: begin
				decodedOp = opAddiuOp;
			end
			opLui: begin
				decodedOp = opLuiOp;
			end
			opLw: begin
				decodedOp = opLwOp;
			end
			opSw: begin
				decodedOp = opSwOp;
			end
			default: begin
				decodedOp = opIllegal;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer import controlUnitPkg::*; (
	input logic clk,
	input logic reset,
	input logic [operationWidth-1:0] decodedOp,
	input logic overflow,
	output logic [stateWidth-1:0] state,
	output logic [operationWidth-1:0] currentOp
);

	logic [stateWidth-1:0] nextState;
	logic [waitCountWidth-1:0] waitCount;
	logic waitDone;
	logic waitState;

	// fetch and load wait both hold for the memory latency
	assign waitState = (state == stFetch) || (state == stLoadWait);
	assign waitDone = (waitCount == waitCountWidth'(memWaitCycles - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stFetch;
			waitCount <= '0;
			currentOp <= opIllegal;
		end else begin
			state <= nextState;
			if (waitState && !waitDone) begin
				waitCount <= waitCount + 1'b1;
			end else begin
				waitCount <= '0;
			end
			if (state == stDecode) begin
				currentOp <= decodedOp;
			end
		end
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stFetch: begin
				nextState = waitDone ? stFetchWrite : stFetch;
			end
			stFetchWrite: begin
				nextState = stDecode;
			end
			stDecode: begin
				// branch by operation class
				case (decodedOp)
					opAddOp, opSubOp, opAndOp, opSltOp: nextState = stAluExecute;
					opSllOp, opSrlOp, opSraOp, opSllvOp, opSravOp,
					opLuiOp: nextState = stShiftExecute;
					opAddiOp, opAddiuOp: nextState = stImmExecute;
					opLwOp, opSwOp: nextState = stAddressCompute;
					opJOp: nextState = stJump;
					opJalOp: nextState = stJumpLink;
					opJrOp: nextState = stJumpRegister;
					opRteOp: nextState = stReturn;
					default: nextState = stIllegalTrap;
				endcase
			end
			stAluExecute: begin
				// and and slt never trap
				if (overflow && (currentOp == opAddOp || currentOp == opSubOp)) begin
					nextState = stOverflowTrap;
				end else begin
					nextState = stAluWriteBack;
				end
			end
			stImmExecute: begin
				// addiu ignores overflow
				if (overflow && currentOp == opAddiOp) begin
					nextState = stOverflowTrap;
				end else begin
					nextState = stImmWriteBack;
				end
			end
			stShiftExecute: begin
				nextState = stShiftWriteBack;
			end
			stAddressCompute: begin
				nextState = (currentOp == opLwOp) ? stLoadWait : stStoreWrite;
			end
			stLoadWait: begin
				nextState = waitDone ? stLoadWriteBack : stLoadWait;
			end
			stJumpLink: begin
				nextState = stJump;
			end
			default: begin
				// write-back, jump, return and trap states end the instruction
				nextState = stFetch;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/controlUnitPkg.sv
design/instructionDecoder.sv
design/stateSequencer.sv
design/controlSignalTable.sv
design/controlUnit.sv
verification/controlUnit_sva.sv
verification/controlUnitTb.sv

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb import controlUnitPkg::*; ();

	typedef logic [27:0] controlVec;

	logic clk;
	logic reset;
	logic [instrWidth-1:0] instruction;
	logic overflow;
	logic iorD;
	logic irWrite;
	logic [1:0] pcSource;
	logic pcWrite;
	logic memRead;
	logic memWrite;
	logic exceptionVector;
	logic [1:0] memToReg;
	logic aluSrcA;
	logic [1:0] aluSrcB;
	logic [2:0] aluOp;
	logic [1:0] shiftOp;
	logic [1:0] shiftAmountSrc;
	logic shiftValueSrc;
	logic [1:0] intCause;
	logic causeWrite;
	logic epcWrite;
	logic [1:0] regDst;
	logic regWrite;

	int errorCount;
	int checkCount;
	int timeoutCount;
	int cycleIndex;
	int seed;
	string testName;
	string checkName;
	controlVec expected;
	controlVec actual;

	controlUnit UUT (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.overflow(overflow),
		.iorD(iorD),
		.irWrite(irWrite),
		.pcSource(pcSource),
		.pcWrite(pcWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.exceptionVector(exceptionVector),
		.memToReg(memToReg),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.shiftAmountSrc(shiftAmountSrc),
		.shiftValueSrc(shiftValueSrc),
		.intCause(intCause),
		.causeWrite(causeWrite),
		.epcWrite(epcWrite),
		.regDst(regDst),
		.regWrite(regWrite)
	);

	always #2 clk = ~clk;

	function automatic logic [instrWidth-1:0] makeRType(input logic [4:0] rs, rt, rd, shamt,
		input logic [functWidth-1:0] funct);
		return {opRType, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [instrWidth-1:0] makeIType(input logic [opcodeWidth-1:0] opcode,
		input logic [4:0] rs, rt, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	// instruction class straight from the opcode and funct tables
	function automatic logic [operationWidth-1:0] classifyInstruction(
		input logic [instrWidth-1:0] instr);
		logic [5:0] opcode;
		logic [5:0] funct;
		logic shamtZero;
		logic [operationWidth-1:0] op;
		opcode = instr[31:26];
		funct = instr[5:0];
		shamtZero = (instr[10:6] == 5'd0);
		op = opIllegal;
		case (opcode)
			opRType: begin
				case (funct)
					fnSll: op = opSllOp;
					fnSrl: op = opSrlOp;
					fnSra: op = opSraOp;
					fnSllv: op = shamtZero ? opSllvOp : opIllegal;
					fnSrav: op = shamtZero ? opSravOp : opIllegal;
					fnJr: op = shamtZero ? opJrOp : opIllegal;
					fnRte: op = shamtZero ? opRteOp : opIllegal;
					fnAdd: op = shamtZero ? opAddOp : opIllegal;
					fnSub: op = shamtZero ? opSubOp : opIllegal;
					fnAnd: op = shamtZero ? opAndOp : opIllegal;
					fnSlt: op = shamtZero ? opSltOp : opIllegal;
					default: op = opIllegal;
				endcase
			end
			opJ: op = opJOp;
			opJal: op = opJalOp;
			opAddi: op = opAddiOp;
			opAddiu: op = opAddiuOp;
			opLui: op = opLuiOp;
			opLw: op = opLwOp;
			opSw: op = opSwOp;
			default: op = opIllegal;
		endcase
		return op;
	endfunction

	// fetch, fetch-write and decode come first for every instruction
	function automatic int instructionLength(input logic [operationWidth-1:0] op);
		case (op)
			opLwOp: return memWaitCycles + 4 + memWaitCycles;
			opJOp, opJrOp, opRteOp, opIllegal: return memWaitCycles + 3;
			default: return memWaitCycles + 4;
		endcase
	endfunction

	function automatic logic [stateWidth-1:0] stepOf(input logic [operationWidth-1:0] op,
		input logic ovf, input int idx);
		int phase;
		logic trap;
		phase = idx - (memWaitCycles + 2);
		trap = ovf && (op == opAddOp || op == opSubOp || op == opAddiOp);
		if (idx < memWaitCycles) begin
			return stFetch;
		end else if (idx == memWaitCycles) begin
			return stFetchWrite;
		end else if (phase < 0) begin
			return stDecode;
		end
		case (op)
			opAddOp, opSubOp, opAndOp, opSltOp:
				return (phase == 0) ? stAluExecute : (trap ? stOverflowTrap : stAluWriteBack);
			opAddiOp, opAddiuOp:
				return (phase == 0) ? stImmExecute : (trap ? stOverflowTrap : stImmWriteBack);
			opSllOp, opSrlOp, opSraOp, opSllvOp, opSravOp, opLuiOp:
				return (phase == 0) ? stShiftExecute : stShiftWriteBack;
			opLwOp: begin
				if (phase == 0) begin
					return stAddressCompute;
				end
				return (phase > memWaitCycles) ? stLoadWriteBack : stLoadWait;
			end
			opSwOp: return (phase == 0) ? stAddressCompute : stStoreWrite;
			opJOp: return stJump;
			opJalOp: return (phase == 0) ? stJumpLink : stJump;
			opJrOp: return stJumpRegister;
			opRteOp: return stReturn;
			default: return stIllegalTrap;
		endcase
	endfunction

	// full output vector for one cycle of one instruction
	function automatic controlVec expectedControls(input logic [instrWidth-1:0] instr,
		input logic ovf, input int idx);
		logic [operationWidth-1:0] op;
		logic [stateWidth-1:0] st;
		logic iorDExp, irWriteExp, pcWriteExp, memReadExp, memWriteExp;
		logic causeWriteExp, epcWriteExp, regWriteExp;
		logic exceptionVectorExp, aluSrcAExp, shiftValueSrcExp;
		logic [1:0] pcSourceExp, memToRegExp, aluSrcBExp, shiftOpExp;
		logic [1:0] shiftAmountSrcExp, intCauseExp, regDstExp;
		logic [2:0] aluOpExp;
		op = classifyInstruction(instr);
		st = stepOf(op, ovf, idx);
		{iorDExp, irWriteExp, pcSourceExp, pcWriteExp, memReadExp, memWriteExp,
			exceptionVectorExp, memToRegExp, aluSrcAExp, aluSrcBExp, aluOpExp, shiftOpExp,
			shiftAmountSrcExp, shiftValueSrcExp, intCauseExp, causeWriteExp, epcWriteExp,
			regDstExp, regWriteExp} = 28'd0;
		case (st)
			stFetch: begin
				memReadExp = 1'b1;
				aluSrcAExp = srcAPc;
				aluSrcBExp = srcBFour;
				aluOpExp = aluAdd;
			end
			stFetchWrite: begin
				irWriteExp = 1'b1;
				pcWriteExp = 1'b1;
				pcSourceExp = pcAluResult;
				aluSrcBExp = srcBFour;
				aluOpExp = aluAdd;
			end
			stDecode: begin
				aluSrcBExp = srcBImmShifted;
				aluOpExp = aluAdd;
			end
			stAluExecute: begin
				aluSrcAExp = srcARegA;
				aluSrcBExp = srcBRegB;
				case (op)
					opAddOp: aluOpExp = aluAdd;
					opSubOp: aluOpExp = aluSub;
					opAndOp: aluOpExp = aluAnd;
					default: aluOpExp = aluSlt;
				endcase
			end
			stImmExecute, stAddressCompute: begin
				aluSrcAExp = srcARegA;
				aluSrcBExp = srcBImm;
				aluOpExp = aluAdd;
			end
			stAluWriteBack: begin
				regDstExp = dstRd;
				memToRegExp = wbAluOut;
				regWriteExp = 1'b1;
			end
			stImmWriteBack: begin
				regDstExp = dstRt;
				memToRegExp = wbAluOut;
				regWriteExp = 1'b1;
			end
			stShiftExecute: begin
				// lui is a left shift of the immediate by sixteen
				if (op == opSrlOp) begin
					shiftOpExp = shSrl;
				end else if (op == opSraOp || op == opSravOp) begin
					shiftOpExp = shSra;
				end else begin
					shiftOpExp = shSll;
				end
				if (op == opSllvOp || op == opSravOp) begin
					shiftAmountSrcExp = amtRs;
				end else if (op == opLuiOp) begin
					shiftAmountSrcExp = amtSixteen;
				end else begin
					shiftAmountSrcExp = amtShamt;
				end
				shiftValueSrcExp = (op == opLuiOp) ? valImmediate : valRt;
			end
			stShiftWriteBack: begin
				memToRegExp = wbShiftResult;
				regDstExp = (op == opLuiOp) ? dstRt : dstRd;
				regWriteExp = 1'b1;
			end
			stLoadWait: begin
				iorDExp = 1'b1;
				memReadExp = 1'b1;
			end
			stLoadWriteBack: begin
				regDstExp = dstRt;
				memToRegExp = wbMemData;
				regWriteExp = 1'b1;
			end
			stStoreWrite: begin
				iorDExp = 1'b1;
				memWriteExp = 1'b1;
			end
			stJumpLink: begin
				regDstExp = dstRa;
				memToRegExp = wbPcLink;
				regWriteExp = 1'b1;
			end
			stJump: begin
				pcSourceExp = pcJumpTarget;
				pcWriteExp = 1'b1;
			end
			stJumpRegister: begin
				aluSrcAExp = srcARegA;
				aluOpExp = aluLoad;
				pcSourceExp = pcAluResult;
				pcWriteExp = 1'b1;
			end
			stReturn: begin
				pcSourceExp = pcEpc;
				pcWriteExp = 1'b1;
			end
			default: begin
				// both traps
				aluSrcAExp = srcAPc;
				aluSrcBExp = srcBFour;
				aluOpExp = aluSub;
				epcWriteExp = 1'b1;
				causeWriteExp = 1'b1;
				pcSourceExp = pcExceptionVector;
				pcWriteExp = 1'b1;
				intCauseExp = (st == stOverflowTrap) ? causeOverflow : causeIllegal;
				exceptionVectorExp = (st == stOverflowTrap) ? vecOverflow : vecIllegal;
			end
		endcase
		return {iorDExp, irWriteExp, pcSourceExp, pcWriteExp, memReadExp, memWriteExp,
			exceptionVectorExp, memToRegExp, aluSrcAExp, aluSrcBExp, aluOpExp, shiftOpExp,
			shiftAmountSrcExp, shiftValueSrcExp, intCauseExp, causeWriteExp, epcWriteExp,
			regDstExp, regWriteExp};
	endfunction

	// outputs are registered, so values before the edge belong to the cycle just ended
	always @(posedge clk) begin
		if (reset) begin
			cycleIndex = 0;
		end else begin
			expected = expectedControls(instruction, overflow, cycleIndex);
			actual = {iorD, irWrite, pcSource, pcWrite, memRead, memWrite, exceptionVector,
				memToReg, aluSrcA, aluSrcB, aluOp, shiftOp, shiftAmountSrc, shiftValueSrc,
				intCause, causeWrite, epcWrite, regDst, regWrite};
			checkCount++;
			if (cycleIndex < memWaitCycles + 2) begin
				checkName = "fetch";
			end else begin
				checkName = testName;
			end
			if (actual !== expected) begin
				errorCount++;
				$display("ERR %s cycle %0d: expected %h, actual %h", checkName, cycleIndex,
					expected, actual);
			end
			cycleIndex++;
			if (cycleIndex >= instructionLength(classifyInstruction(instruction))) begin
				cycleIndex = 0;
			end
		end
	end

	task automatic finishRun();
		$display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
			checkCount, errorCount, UUT.sva.failureCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && UUT.sva.failureCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// after a timeout every later wait is skipped so the run ends at once
	task automatic waitForIrWrite();
		int waited;
		waited = 0;
		if (timeoutCount == 0) begin
			@(posedge clk);
			while (irWrite !== 1'b1 && waited < 20) begin
				@(posedge clk);
				waited++;
			end
			if (irWrite !== 1'b1) begin
				timeoutCount++;
				$display("timeout: irWrite did not rise within 20 cycles after %s", testName);
			end
		end
	endtask

	// new word goes in during decode and stays until the next fetch-write
	task automatic runInstruction(input string name, input logic [instrWidth-1:0] instr,
		input logic ovf);
		waitForIrWrite();
		if (timeoutCount == 0) begin
			#1;
			instruction = instr;
			overflow = ovf;
			testName = name;
		end
	endtask

	function automatic logic [opcodeWidth-1:0] legalOpcode(input int pick);
		case (pick)
			0, 1: return opRType;
			2: return opJ;
			3: return opJal;
			4: return opAddi;
			5: return opAddiu;
			6: return opLui;
			7: return opLw;
			default: return opSw;
		endcase
	endfunction

	function automatic logic [functWidth-1:0] legalFunct(input int pick);
		case (pick)
			0: return fnSll;
			1: return fnSrl;
			2: return fnSra;
			3: return fnSllv;
			4: return fnSrav;
			5: return fnJr;
			6: return fnRte;
			7: return fnAdd;
			8: return fnSub;
			9: return fnAnd;
			default: return fnSlt;
		endcase
	endfunction

	task automatic runRandomInstructions(input int count);
		logic [instrWidth-1:0] word;
		logic ovf;
		int pick;
		int n;
		for (n = 0; n < count; n++) begin
			word = $random(seed);
			// a raw opcode now and then keeps illegal words in the mix
			pick = {$random(seed)} % 10;
			if (pick < 9) begin
				word[31:26] = legalOpcode(pick);
			end
			if (word[31:26] == opRType) begin
				pick = {$random(seed)} % 12;
				if (pick < 11) begin
					word[5:0] = legalFunct(pick);
				end
				if (($random(seed) % 2) != 0) begin
					word[10:6] = 5'd0;
				end
			end
			ovf = ($random(seed) % 2) != 0;
			runInstruction($sformatf("random %0d", n), word, ovf);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instruction = '0;
		overflow = 1'b0;
		errorCount = 0;
		checkCount = 0;
		timeoutCount = 0;
		cycleIndex = 0;
		seed = 53;
		testName = "reset";
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		runInstruction("add", makeRType(5'd1, 5'd2, 5'd3, 5'd0, fnAdd), 1'b0);
		runInstruction("sub", makeRType(5'd4, 5'd5, 5'd6, 5'd0, fnSub), 1'b0);
		runInstruction("and", makeRType(5'd7, 5'd8, 5'd9, 5'd0, fnAnd), 1'b0);
		runInstruction("slt", makeRType(5'd1, 5'd3, 5'd5, 5'd0, fnSlt), 1'b0);
		runInstruction("sll", makeRType(5'd0, 5'd2, 5'd3, 5'd4, fnSll), 1'b0);
		runInstruction("srl", makeRType(5'd0, 5'd2, 5'd3, 5'd7, fnSrl), 1'b0);
		runInstruction("sra", makeRType(5'd0, 5'd2, 5'd3, 5'd31, fnSra), 1'b0);
		runInstruction("sllv", makeRType(5'd6, 5'd2, 5'd3, 5'd0, fnSllv), 1'b0);
		runInstruction("srav", makeRType(5'd6, 5'd2, 5'd3, 5'd0, fnSrav), 1'b0);
		runInstruction("lui", makeIType(opLui, 5'd0, 5'd5, 16'h1234), 1'b0);
		runInstruction("addi", makeIType(opAddi, 5'd1, 5'd2, 16'hfff0), 1'b0);
		runInstruction("addiu", makeIType(opAddiu, 5'd1, 5'd2, 16'h0010), 1'b0);
		runInstruction("lw", makeIType(opLw, 5'd29, 5'd8, 16'h0004), 1'b0);
		runInstruction("sw", makeIType(opSw, 5'd29, 5'd8, 16'h0008), 1'b0);
		runInstruction("j", makeIType(opJ, 5'd0, 5'd0, 16'h0040), 1'b0);
		runInstruction("jal", makeIType(opJal, 5'd0, 5'd0, 16'h0080), 1'b0);
		runInstruction("jr", makeRType(5'd31, 5'd0, 5'd0, 5'd0, fnJr), 1'b0);
		runInstruction("rte", makeRType(5'd0, 5'd0, 5'd0, 5'd0, fnRte), 1'b0);

		// overflow traps only add, sub and addi
		runInstruction("add overflow", makeRType(5'd1, 5'd2, 5'd3, 5'd0, fnAdd), 1'b1);
		runInstruction("sub overflow", makeRType(5'd1, 5'd2, 5'd3, 5'd0, fnSub), 1'b1);
		runInstruction("addi overflow", makeIType(opAddi, 5'd1, 5'd2, 16'h7fff), 1'b1);
		runInstruction("addiu overflow", makeIType(opAddiu, 5'd1, 5'd2, 16'h7fff), 1'b1);
		runInstruction("and overflow", makeRType(5'd1, 5'd2, 5'd3, 5'd0, fnAnd), 1'b1);
		runInstruction("slt overflow", makeRType(5'd1, 5'd2, 5'd3, 5'd0, fnSlt), 1'b1);

		runInstruction("illegal opcode", makeIType(6'd63, 5'd1, 5'd2, 16'h0000), 1'b0);
		runInstruction("illegal funct", makeRType(5'd1, 5'd2, 5'd3, 5'd0, 6'd1), 1'b0);
		runInstruction("add with shamt", makeRType(5'd1, 5'd2, 5'd3, 5'd5, fnAdd), 1'b0);
		runInstruction("jr with shamt", makeRType(5'd31, 5'd0, 5'd0, 5'd3, fnJr), 1'b0);

		runRandomInstructions(200);

		// let the last instruction run to the next fetch-write
		waitForIrWrite();
		#1;
		finishRun();
	end

endmodule

`default_nettype wire

// ==== verification/controlUnit_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitSva (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic irWrite,
	input logic pcWrite,
	input logic regWrite,
	input logic causeWrite,
	input logic epcWrite
);

	int failureCount = 0;

	memExclusive: assert property (@(posedge clk) !(memRead && memWrite))
		else begin
			failureCount++;
			$error("memRead and memWrite high in the same cycle");
		end

	// the instruction register and the PC load together
	fetchWrite: assert property (@(posedge clk) irWrite |-> pcWrite)
		else begin
			failureCount++;
			$error("irWrite high without pcWrite");
		end

	regOrPc: assert property (@(posedge clk) !(regWrite && pcWrite))
		else begin
			failureCount++;
			$error("regWrite and pcWrite high in the same cycle");
		end

	quietReset: assert property (@(posedge clk)
		reset |-> !(irWrite || pcWrite || regWrite || memWrite || causeWrite || epcWrite))
		else begin
			failureCount++;
			$error("write output high during reset");
		end

endmodule

bind controlUnit controlUnitSva sva (
	.clk(clk),
	.reset(reset),
	.memRead(memRead),
	.memWrite(memWrite),
	.irWrite(irWrite),
	.pcWrite(pcWrite),
	.regWrite(regWrite),
	.causeWrite(causeWrite),
	.epcWrite(epcWrite)
);

`default_nettype wire
